//--- hw/cpu_pkg.sv
package cpu_pkg;

    //////////////////////////////////////////////////////////////////////
    // cp0 update kinds and payloads
    //////////////////////////////////////////////////////////////////////

    // what a commit does to cp0 at the apply edge
    typedef enum logic [1:0] {
        NONE = 2'd0,
        EXC  = 2'd1,
        ERET = 2'd2,
        MTC0 = 2'd3
    } cp0_op_t;

    // values an exception writes into cp0
    typedef struct packed {
        logic [31:0] epc;
        logic        cause_bd;
        logic [4:0]  cause_exccode;
        logic [31:0] badvaddr;
    } exc_info_t;

    // one instruction leaving the memory stage
    typedef struct packed {
        logic        is_instr;
        logic [31:0] pc;
        logic        in_delay_slot;
        logic [31:0] badvaddr;
        // see ADDR_ERR_* below
        logic [1:0]  addr_err;
        logic        reserved_instr;
        logic        intovf;
        logic        brk;
        logic        syscall;
        logic        eret;
        logic        mtc0;
        logic        mfc0;
        logic [4:0]  cp0_addr;
        logic [31:0] wdata;
    } commit_t;

    // answer back to the pipeline
    typedef struct packed {
        logic        redirect;
        logic [31:0] target;
        logic [31:0] rdata;
    } result_t;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // cause exccode values
    localparam logic [4:0] EXCCODE_INT  = 5'd0;
    localparam logic [4:0] EXCCODE_ADEL = 5'd4;
    localparam logic [4:0] EXCCODE_ADES = 5'd5;
    localparam logic [4:0] EXCCODE_SYS  = 5'd8;
    localparam logic [4:0] EXCCODE_BP   = 5'd9;
    localparam logic [4:0] EXCCODE_RI   = 5'd10;
    localparam logic [4:0] EXCCODE_OV   = 5'd12;

    // address error source
    localparam logic [1:0] ADDR_ERR_FETCH = 2'b01;
    localparam logic [1:0] ADDR_ERR_LOAD  = 2'b10;
    localparam logic [1:0] ADDR_ERR_STORE = 2'b11;

    // cp0 register numbers
    localparam logic [4:0] CP0_BADVADDR = 5'd8;
    localparam logic [4:0] CP0_STATUS   = 5'd12;
    localparam logic [4:0] CP0_CAUSE    = 5'd13;
    localparam logic [4:0] CP0_EPC      = 5'd14;

    // single-bit fields of status and cause
    localparam int STATUS_IE  = 0;
    localparam int STATUS_EXL = 1;
    localparam int CAUSE_BD   = 31;

endpackage

//--- hw/exc_handler.sv
module exc_handler (
    input  cpu_pkg::commit_t   commit,
    input  logic [31:0]        cp0_status,
    input  logic [31:0]        cp0_cause,
    input  logic [31:0]        cp0_epc,
    output logic               is_valid_exc,
    output cpu_pkg::cp0_op_t   cp0_op,
    output cpu_pkg::exc_info_t exc_info
);

    logic        exl;
    logic        int_pending;
    logic [4:0]  exccode;
    logic [31:0] epc_wdata;
    logic        bd_wdata;

    // already inside a handler
    assign exl = cp0_status[cpu_pkg::STATUS_EXL];

    // some enabled ip bit set, ie on, not nested
    assign int_pending = ((cp0_cause[15:8] & cp0_status[15:8]) != 8'b0)
                      && cp0_status[cpu_pkg::STATUS_IE]
                      && !exl;

    //////////////////////////////////////////////////////////////////////
    // priority chain
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        is_valid_exc = 1'b1;
        exccode      = 5'b0;
        // bubbles never trap
        if (!commit.is_instr) begin
            is_valid_exc = 1'b0;
        end else if (int_pending) begin
            exccode = cpu_pkg::EXCCODE_INT;
        end else if (commit.addr_err == cpu_pkg::ADDR_ERR_FETCH) begin
            exccode = cpu_pkg::EXCCODE_ADEL;
        end else if (commit.reserved_instr) begin
            exccode = cpu_pkg::EXCCODE_RI;
        end else if (commit.intovf) begin
            exccode = cpu_pkg::EXCCODE_OV;
        end else if (commit.brk) begin
            exccode = cpu_pkg::EXCCODE_BP;
        end else if (commit.syscall) begin
            exccode = cpu_pkg::EXCCODE_SYS;
        end else if (commit.addr_err == cpu_pkg::ADDR_ERR_LOAD) begin
            exccode = cpu_pkg::EXCCODE_ADEL;
        end else if (commit.addr_err == cpu_pkg::ADDR_ERR_STORE) begin
            exccode = cpu_pkg::EXCCODE_ADES;
        end else begin
            // nothing to take
            is_valid_exc = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // epc and bd
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (exl) begin
            // nested, keep the outer return point
            epc_wdata = cp0_epc;
            bd_wdata  = cp0_cause[cpu_pkg::CAUSE_BD];
        end else if (commit.in_delay_slot) begin
            // restart at the branch
            epc_wdata = commit.pc - 32'd4;
            bd_wdata  = 1'b1;
        end else begin
            epc_wdata = commit.pc;
            bd_wdata  = 1'b0;
        end
    end

    // exception wins over eret and mtc0
    always_comb begin
        if (is_valid_exc) begin
            cp0_op = cpu_pkg::EXC;
        end else if (commit.eret) begin
            cp0_op = cpu_pkg::ERET;
        end else if (commit.mtc0) begin
            cp0_op = cpu_pkg::MTC0;
        end else begin
            cp0_op = cpu_pkg::NONE;
        end
    end

    assign exc_info.epc           = epc_wdata;
    assign exc_info.cause_bd      = bd_wdata;
    assign exc_info.cause_exccode = exccode;
    // only used for address errors
    assign exc_info.badvaddr      = commit.badvaddr;

endmodule

//--- hw/cp0_regs.sv
module cp0_regs (
    input  logic               clk,
    input  logic               reset,
    input  logic               apply,
    input  cpu_pkg::cp0_op_t   cp0_op,
    input  cpu_pkg::exc_info_t exc_info,
    input  logic [31:0]        wdata,
    input  logic [4:0]         cp0_addr,
    input  logic [5:0]         hw_int,
    output logic [31:0]        cp0_status,
    output logic [31:0]        cp0_cause,
    output logic [31:0]        cp0_epc,
    output logic [31:0]        rdata
);

    // im[15:8], exl and ie
    localparam logic [31:0] STATUS_WMASK = 32'h0000_ff03;

    logic [31:0] status_q;
    logic [31:0] cause_q;
    logic [31:0] epc_q;
    logic [31:0] badvaddr_q;

    logic do_exc;
    logic do_eret;
    logic do_mtc0;
    logic addr_exc;

    // decoded update strobes
    assign do_exc  = apply && (cp0_op == cpu_pkg::EXC);
    assign do_eret = apply && (cp0_op == cpu_pkg::ERET);
    assign do_mtc0 = apply && (cp0_op == cpu_pkg::MTC0);

    // badvaddr only follows address errors
    assign addr_exc = (exc_info.cause_exccode == cpu_pkg::EXCCODE_ADEL)
                   || (exc_info.cause_exccode == cpu_pkg::EXCCODE_ADES);

    //////////////////////////////////////////////////////////////////////
    // status
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            status_q <= '0;
        end else if (do_exc) begin
            status_q[cpu_pkg::STATUS_EXL] <= 1'b1;
        end else if (do_eret) begin
            status_q[cpu_pkg::STATUS_EXL] <= 1'b0;
        end else if (do_mtc0 && (cp0_addr == cpu_pkg::CP0_STATUS)) begin
            // other bits stay zero
            status_q <= wdata & STATUS_WMASK;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // cause
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_q <= '0;
        end else begin
            // hardware lines land in ip[15:10] every cycle
            cause_q[15:10] <= hw_int;
            if (do_exc) begin
                cause_q[cpu_pkg::CAUSE_BD] <= exc_info.cause_bd;
                cause_q[6:2]               <= exc_info.cause_exccode;
            end else if (do_mtc0 && (cp0_addr == cpu_pkg::CP0_CAUSE)) begin
                // software interrupt bits only
                cause_q[9:8] <= wdata[9:8];
            end
        end
    end

    // epc from an exception or a direct write
    always_ff @(posedge clk) begin
        if (reset) begin
            epc_q <= '0;
        end else if (do_exc) begin
            epc_q <= exc_info.epc;
        end else if (do_mtc0 && (cp0_addr == cpu_pkg::CP0_EPC)) begin
            epc_q <= wdata;
        end
    end

    // read-only to software
    always_ff @(posedge clk) begin
        if (reset) begin
            badvaddr_q <= '0;
        end else if (do_exc && addr_exc) begin
            badvaddr_q <= exc_info.badvaddr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reads
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (cp0_addr)
            cpu_pkg::CP0_BADVADDR: rdata = badvaddr_q;
            cpu_pkg::CP0_STATUS:   rdata = status_q;
            cpu_pkg::CP0_CAUSE:    rdata = cause_q;
            cpu_pkg::CP0_EPC:      rdata = epc_q;
            // unmapped
            default:               rdata = '0;
        endcase
    end

    assign cp0_status = status_q;
    assign cp0_cause  = cause_q;
    assign cp0_epc    = epc_q;

    // taking an exception always enters exception level
    assert property (@(posedge clk) disable iff (reset)
        do_exc |=> cp0_status[cpu_pkg::STATUS_EXL])
        else $error("exl not set after an exception was applied");

endmodule

//--- hw/commit_port.sv
module commit_port #(
    parameter logic [31:0] exc_vector = 32'hbfc00380
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             req,
    input  cpu_pkg::commit_t commit,
    output logic             ack,
    output cpu_pkg::result_t result,
    output cpu_pkg::commit_t held,
    output logic             apply,
    input  logic             is_valid_exc,
    input  cpu_pkg::cp0_op_t cp0_op,
    input  logic [31:0]      cp0_epc,
    input  logic [31:0]      rdata
);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } state_t;

    state_t           state;
    cpu_pkg::result_t result_next;

    // cp0 updates at the edge that leaves busy
    assign apply = (state == BUSY);

    // held commit only loads on acceptance
    always_ff @(posedge clk) begin
        if ((state == IDLE) && req) begin
            held <= commit;
        end
    end

    // result of the held commit
    always_comb begin
        result_next.redirect = 1'b0;
        result_next.target   = '0;
        if (is_valid_exc) begin
            result_next.redirect = 1'b1;
            result_next.target   = exc_vector;
        end else if (cp0_op == cpu_pkg::ERET) begin
            // back to the saved return point
            result_next.redirect = 1'b1;
            result_next.target   = cp0_epc;
        end
        result_next.rdata = held.mfc0 ? rdata : '0;
    end

    //////////////////////////////////////////////////////////////////////
    // handshake fsm
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            ack    <= 1'b0;
            result <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    state  <= DONE;
                    ack    <= 1'b1;
                    result <= result_next;
                end
                DONE: begin
                    // hold until the requester lets go
                    if (!req) begin
                        state <= IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // four-phase rule on our side
    assert property (@(posedge clk) disable iff (reset) (ack && req) |=> ack)
        else $error("ack dropped while req still high");

endmodule

//--- hw/exc_unit.sv
module exc_unit #(
    parameter logic [31:0] exc_vector = 32'hbfc00380
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             req,
    input  cpu_pkg::commit_t commit,
    output logic             ack,
    output cpu_pkg::result_t result,
    input  logic [5:0]       hw_int
);

    // port to handler
    cpu_pkg::commit_t   held;
    logic               apply;

    // handler to port and registers
    logic               is_valid_exc;
    cpu_pkg::cp0_op_t   cp0_op;
    cpu_pkg::exc_info_t exc_info;

    // register state
    logic [31:0]        cp0_status;
    logic [31:0]        cp0_cause;
    logic [31:0]        cp0_epc;
    logic [31:0]        rdata;

    //////////////////////////////////////////////////////////////////////
    // handshake and result
    //////////////////////////////////////////////////////////////////////

    commit_port #(
        .exc_vector(exc_vector)
    ) i_commit_port (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .commit      (commit),
        .ack         (ack),
        .result      (result),
        .held        (held),
        .apply       (apply),
        .is_valid_exc(is_valid_exc),
        .cp0_op      (cp0_op),
        .cp0_epc     (cp0_epc),
        .rdata       (rdata)
    );

    // priority decode of the held commit
    exc_handler i_exc_handler (
        .commit      (held),
        .cp0_status  (cp0_status),
        .cp0_cause   (cp0_cause),
        .cp0_epc     (cp0_epc),
        .is_valid_exc(is_valid_exc),
        .cp0_op      (cp0_op),
        .exc_info    (exc_info)
    );

    // mtc0 and mfc0 share the held address
    cp0_regs i_cp0_regs (
        .clk       (clk),
        .reset     (reset),
        .apply     (apply),
        .cp0_op    (cp0_op),
        .exc_info  (exc_info),
        .wdata     (held.wdata),
        .cp0_addr  (held.cp0_addr),
        .hw_int    (hw_int),
        .cp0_status(cp0_status),
        .cp0_cause (cp0_cause),
        .cp0_epc   (cp0_epc),
        .rdata     (rdata)
    );

endmodule

//--- bench/tb_clock.sv
module tb_clock #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 16,
    parameter int drive_delay  = 2
) (
    output logic clk,
    output logic reset
);

    // free running, period of two half periods
    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release lands just after an edge, same as the other inputs
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
    end

endmodule

//--- bench/tb_exc_unit.sv
module tb_exc_unit;

    // deliberately not the default vector
    localparam logic [31:0] exc_vector     = 32'h8000_0180;
    localparam int          timeout_cycles = 50;

    logic             clk;
    logic             reset;
    logic             req;
    cpu_pkg::commit_t commit;
    logic             ack;
    cpu_pkg::result_t result;
    logic [5:0]       hw_int;

    integer      seed;
    // last badvaddr an address error left behind
    logic [31:0] exp_badvaddr;

    tb_clock #(
        .half_period (10),
        .reset_cycles(16),
        .drive_delay (2)
    ) i_clock (
        .clk  (clk),
        .reset(reset)
    );

    exc_unit #(
        .exc_vector(exc_vector)
    ) i_dut (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .commit(commit),
        .ack   (ack),
        .result(result),
        .hw_int(hw_int)
    );

    //////////////////////////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////////////////////////

    task stop_on_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at first failure");
    endtask

    task check_value(input string name, input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task report_timeout(input string what);
        $display("timeout: DUT never showed %s", what);
        stop_on_failure();
    endtask

    // one edge and the drive delay after it
    task next_cycle();
        @(posedge clk);
        #2;
    endtask

    //////////////////////////////////////////////////////////////////////
    // commit helpers
    //////////////////////////////////////////////////////////////////////

    // word aligned random pc
    function logic [31:0] random_pc();
        return $random(seed) & 32'hffff_fffc;
    endfunction

    // an ordinary instruction with no flags
    function cpu_pkg::commit_t plain_instr();
        cpu_pkg::commit_t c;
        c          = '0;
        c.is_instr = 1'b1;
        c.pc       = random_pc();
        return c;
    endfunction

    // full four-phase transfer with ack timing checks
    task do_commit(input cpu_pkg::commit_t c, output cpu_pkg::result_t r);
        int count;
        count  = 0;
        req    = 1'b1;
        commit = c;
        while (!ack) begin
            next_cycle();
            count++;
            if (count > timeout_cycles) report_timeout("ack high");
        end
        // capture edge plus apply edge
        check_value("ack latency", count, 2);
        r     = result;
        req   = 1'b0;
        count = 0;
        while (ack) begin
            next_cycle();
            count++;
            if (count > timeout_cycles) report_timeout("ack low");
        end
        check_value("ack release latency", count, 1);
        commit = '0;
    endtask

    task read_cp0(input logic [4:0] addr, output logic [31:0] value);
        cpu_pkg::commit_t c;
        cpu_pkg::result_t r;
        c          = plain_instr();
        c.mfc0     = 1'b1;
        c.cp0_addr = addr;
        do_commit(c, r);
        check_value("mfc0 redirect", r.redirect, 1'b0);
        value = r.rdata;
    endtask

    task expect_cp0(input string name, input logic [4:0] addr, input logic [31:0] expected);
        logic [31:0] value;
        read_cp0(addr, value);
        check_value(name, value, expected);
    endtask

    task write_cp0(input logic [4:0] addr, input logic [31:0] data);
        cpu_pkg::commit_t c;
        cpu_pkg::result_t r;
        c          = plain_instr();
        c.mtc0     = 1'b1;
        c.cp0_addr = addr;
        c.wdata    = data;
        do_commit(c, r);
        check_value("mtc0 redirect", r.redirect, 1'b0);
        check_value("mtc0 rdata", r.rdata, 32'h0);
    endtask

    task plain_no_redirect();
        cpu_pkg::result_t r;
        do_commit(plain_instr(), r);
        check_value("plain redirect", r.redirect, 1'b0);
    endtask

    task expect_exception(input cpu_pkg::commit_t c);
        cpu_pkg::result_t r;
        do_commit(c, r);
        check_value("exception redirect", r.redirect, 1'b1);
        check_value("exception target", r.target, exc_vector);
    endtask

    task do_eret(input logic [31:0] target);
        cpu_pkg::commit_t c;
        cpu_pkg::result_t r;
        c      = plain_instr();
        c.eret = 1'b1;
        do_commit(c, r);
        check_value("eret redirect", r.redirect, 1'b1);
        check_value("eret target", r.target, target);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task test_reset_and_mfc0();
        expect_cp0("status after reset", cpu_pkg::CP0_STATUS, 32'h0);
        expect_cp0("cause after reset", cpu_pkg::CP0_CAUSE, 32'h0);
        expect_cp0("epc after reset", cpu_pkg::CP0_EPC, 32'h0);
        expect_cp0("badvaddr after reset", cpu_pkg::CP0_BADVADDR, 32'h0);
        expect_cp0("unmapped read", 5'd3, 32'h0);
        // only im, exl and ie stick
        write_cp0(cpu_pkg::CP0_STATUS, 32'hffff_ffff);
        expect_cp0("status writable bits", cpu_pkg::CP0_STATUS, 32'h0000_ff03);
        write_cp0(cpu_pkg::CP0_STATUS, 32'h0);
        expect_cp0("status cleared", cpu_pkg::CP0_STATUS, 32'h0);
    endtask

    // one synchronous exception with exl clear and its eret
    task sync_case(input logic [1:0] addr_err, input logic ri, input logic ov,
                   input logic bp, input logic sys, input logic [4:0] code);
        cpu_pkg::commit_t c;
        c                = plain_instr();
        c.badvaddr       = $random(seed);
        c.addr_err       = addr_err;
        c.reserved_instr = ri;
        c.intovf         = ov;
        c.brk            = bp;
        c.syscall        = sys;
        expect_exception(c);
        if ((code == cpu_pkg::EXCCODE_ADEL) || (code == cpu_pkg::EXCCODE_ADES)) begin
            exp_badvaddr = c.badvaddr;
        end
        expect_cp0("cause exccode", cpu_pkg::CP0_CAUSE, {25'b0, code, 2'b0});
        expect_cp0("epc", cpu_pkg::CP0_EPC, c.pc);
        expect_cp0("badvaddr", cpu_pkg::CP0_BADVADDR, exp_badvaddr);
        expect_cp0("status exl set", cpu_pkg::CP0_STATUS, 32'h2);
        do_eret(c.pc);
        expect_cp0("status exl clear", cpu_pkg::CP0_STATUS, 32'h0);
    endtask

    task test_sync_priority();
        // addr_err ri ov bp sys
        sync_case(2'b00, 1'b0, 1'b0, 1'b0, 1'b1, cpu_pkg::EXCCODE_SYS);
        sync_case(2'b00, 1'b0, 1'b0, 1'b1, 1'b1, cpu_pkg::EXCCODE_BP);
        sync_case(2'b00, 1'b0, 1'b1, 1'b1, 1'b0, cpu_pkg::EXCCODE_OV);
        sync_case(2'b00, 1'b1, 1'b1, 1'b0, 1'b1, cpu_pkg::EXCCODE_RI);
        sync_case(2'b01, 1'b1, 1'b1, 1'b1, 1'b1, cpu_pkg::EXCCODE_ADEL);
        // load error loses to syscall and leaves badvaddr alone
        sync_case(2'b10, 1'b0, 1'b0, 1'b0, 1'b1, cpu_pkg::EXCCODE_SYS);
        sync_case(2'b10, 1'b0, 1'b0, 1'b0, 1'b0, cpu_pkg::EXCCODE_ADEL);
        sync_case(2'b11, 1'b0, 1'b0, 1'b0, 1'b0, cpu_pkg::EXCCODE_ADES);
        sync_case(2'b11, 1'b0, 1'b0, 1'b1, 1'b0, cpu_pkg::EXCCODE_BP);
    endtask

    task test_delay_slot_nesting();
        cpu_pkg::commit_t first;
        cpu_pkg::commit_t second;
        first               = plain_instr();
        first.in_delay_slot = 1'b1;
        first.syscall       = 1'b1;
        expect_exception(first);
        expect_cp0("cause bd", cpu_pkg::CP0_CAUSE, 32'h8000_0020);
        expect_cp0("epc in delay slot", cpu_pkg::CP0_EPC, first.pc - 32'd4);
        // nested exception moves exccode but keeps epc and bd
        second     = plain_instr();
        second.brk = 1'b1;
        expect_exception(second);
        expect_cp0("nested cause", cpu_pkg::CP0_CAUSE, 32'h8000_0024);
        expect_cp0("nested epc", cpu_pkg::CP0_EPC, first.pc - 32'd4);
        expect_cp0("nested status", cpu_pkg::CP0_STATUS, 32'h2);
        do_eret(first.pc - 32'd4);
        expect_cp0("status after eret", cpu_pkg::CP0_STATUS, 32'h0);
    endtask

    task test_eret_and_bubble();
        cpu_pkg::commit_t c;
        cpu_pkg::result_t r;
        logic [31:0]      epc_value;
        epc_value = $random(seed);
        write_cp0(cpu_pkg::CP0_EPC, epc_value);
        do_eret(epc_value);
        expect_cp0("status after plain eret", cpu_pkg::CP0_STATUS, 32'h0);
        // bd and break code left by the nested exception
        expect_cp0("cause before bubble", cpu_pkg::CP0_CAUSE, 32'h8000_0024);
        // bubble carrying stale flags
        c                = plain_instr();
        c.is_instr       = 1'b0;
        c.addr_err       = 2'b01;
        c.reserved_instr = 1'b1;
        c.brk            = 1'b1;
        c.syscall        = 1'b1;
        do_commit(c, r);
        check_value("bubble redirect", r.redirect, 1'b0);
        check_value("bubble target", r.target, 32'h0);
        check_value("bubble rdata", r.rdata, 32'h0);
        expect_cp0("status after bubble", cpu_pkg::CP0_STATUS, 32'h0);
        expect_cp0("cause after bubble", cpu_pkg::CP0_CAUSE, 32'h8000_0024);
        expect_cp0("epc after bubble", cpu_pkg::CP0_EPC, epc_value);
        expect_cp0("badvaddr after bubble", cpu_pkg::CP0_BADVADDR, exp_badvaddr);
    endtask

    task test_interrupts();
        cpu_pkg::commit_t c;
        // hw line 0 lands in ip10
        hw_int = 6'b000001;
        write_cp0(cpu_pkg::CP0_STATUS, 32'h0000_0401);
        c = plain_instr();
        expect_exception(c);
        expect_cp0("cause hw int", cpu_pkg::CP0_CAUSE, 32'h0000_0400);
        expect_cp0("epc hw int", cpu_pkg::CP0_EPC, c.pc);
        // exl set masks it
        plain_no_redirect();
        // im10 and exl both off
        write_cp0(cpu_pkg::CP0_STATUS, 32'h0000_0001);
        plain_no_redirect();
        hw_int = 6'b000000;
        // software interrupt through ip8
        write_cp0(cpu_pkg::CP0_CAUSE, 32'h0000_0100);
        write_cp0(cpu_pkg::CP0_STATUS, 32'h0000_0101);
        c = plain_instr();
        expect_exception(c);
        expect_cp0("cause sw int", cpu_pkg::CP0_CAUSE, 32'h0000_0100);
        expect_cp0("epc sw int", cpu_pkg::CP0_EPC, c.pc);
        write_cp0(cpu_pkg::CP0_STATUS, 32'h0);
        write_cp0(cpu_pkg::CP0_CAUSE, 32'h0);
        expect_cp0("cause cleared", cpu_pkg::CP0_CAUSE, 32'h0);
    endtask

    task test_handshake();
        cpu_pkg::commit_t c;
        cpu_pkg::result_t held_result;
        logic [31:0]      epc_value;
        int               count;
        epc_value = $random(seed);
        write_cp0(cpu_pkg::CP0_EPC, epc_value);
        c          = plain_instr();
        c.mfc0     = 1'b1;
        c.cp0_addr = cpu_pkg::CP0_EPC;
        req        = 1'b1;
        commit     = c;
        count      = 0;
        while (!ack) begin
            next_cycle();
            count++;
            if (count > timeout_cycles) report_timeout("ack high");
        end
        check_value("held ack latency", count, 2);
        held_result = result;
        check_value("held rdata", held_result.rdata, epc_value);
        // requester stalls with req up
        repeat (5) begin
            next_cycle();
            check_value("ack while req held", ack, 1'b1);
            check_value("result stable", result == held_result, 1'b1);
        end
        req   = 1'b0;
        count = 0;
        while (ack) begin
            next_cycle();
            count++;
            if (count > timeout_cycles) report_timeout("ack low");
        end
        check_value("held release latency", count, 1);
        // next transfer starts right away
        expect_cp0("epc after stall", cpu_pkg::CP0_EPC, epc_value);
    endtask

    //////////////////////////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int count;
        req          = 1'b0;
        commit       = '0;
        hw_int       = 6'b0;
        seed         = 32'hdadd;
        exp_badvaddr = 32'h0;
        count        = 0;
        do begin
            @(posedge clk);
            count++;
            if (count > 4 * timeout_cycles) report_timeout("reset release");
        end while (reset !== 1'b0);
        #2;
        test_reset_and_mfc0();
        test_sync_priority();
        test_delay_slot_nesting();
        test_eret_and_bubble();
        test_interrupts();
        test_handshake();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- exc_unit.f
hw/cpu_pkg.sv
hw/exc_handler.sv
hw/cp0_regs.sv
hw/commit_port.sv
hw/exc_unit.sv
bench/tb_clock.sv
bench/tb_exc_unit.sv

//--- Bender.yml
package:
  name: exc_unit

sources:
  - hw/cpu_pkg.sv
  - hw/exc_handler.sv
  - hw/cp0_regs.sv
  - hw/commit_port.sv
  - hw/exc_unit.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/tb_exc_unit.sv
